// ==== compile.f ====
source/hdr_mem_pkg.sv
source/hdr_pixel_pkg.sv
source/hdr_ifs.sv
source/exposure_fetch.sv
source/pixel_unpack.sv
source/hdr_merge.sv
source/hdr_result.sv
source/hdr_image_top.sv
verif/tb_hdr_image.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the HDR image testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_hdr_image -f compile.f -o sim_tb_hdr_image
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_hdr_image > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== verif/hdr_testdata.hex ====
// Per line: slot, camera word, first read word, second read word, eight expected RGB888 pixels
// Read words come lower exposure first, expected pixels run from pixel 0 to pixel 7
0 21082108044221082108044221082108 10848420FFFF10848420FFFF10848420 FFFF1084FFFFFFFF1084FFFFFFFF1084 212021 424142 424121 212021 424142 424121 212021 424142
0 21080442210821080442210821080442 8420FFFF10848420FFFF10848420FFFF 1084FFFFFFFF1084FFFFFFFF1084FFFF 424121 212021 424142 424121 212021 424142 424121 212021
1 8420FFFF10848420FFFF10848420FFFF 21080442210821080442210821080442 1084FFFFFFFF1084FFFFFFFF1084FFFF 424121 212021 424142 424121 212021 424142 424121 212021
1 10848420FFFF10848420FFFF10848420 21082108044221082108044221082108 FFFF1084FFFFFFFF1084FFFFFFFF1084 212021 424142 424121 212021 424142 424121 212021 424142
2 FFFF1084FFFFFFFF1084FFFFFFFF1084 21082108044221082108044221082108 10848420FFFF10848420FFFF10848420 212021 424142 424121 212021 424142 424121 212021 424142
2 1084FFFFFFFF1084FFFFFFFF1084FFFF 21080442210821080442210821080442 8420FFFF10848420FFFF10848420FFFF 424121 212021 424142 424121 212021 424142 424121 212021
3 21080442210821080442210821080442 8420FFFF10848420FFFF10848420FFFF 1084FFFFFFFF1084FFFFFFFF1084FFFF 424121 212021 424142 424121 212021 424142 424121 212021
3 21082108044221082108044221082108 10848420FFFF10848420FFFF10848420 FFFF1084FFFFFFFF1084FFFFFFFF1084 212021 424142 424121 212021 424142 424121 212021 424142
4 10848420FFFF10848420FFFF10848420 21082108044221082108044221082108 FFFF1084FFFFFFFF1084FFFFFFFF1084 212021 424142 424121 212021 424142 424121 212021 424142
4 8420FFFF10848420FFFF10848420FFFF 21080442210821080442210821080442 1084FFFFFFFF1084FFFFFFFF1084FFFF 424121 212021 424142 424121 212021 424142 424121 212021
5 1084FFFFFFFF1084FFFFFFFF1084FFFF 21080442210821080442210821080442 8420FFFF10848420FFFF10848420FFFF 424121 212021 424142 424121 212021 424142 424121 212021
5 FFFF1084FFFFFFFF1084FFFFFFFF1084 21082108044221082108044221082108 10848420FFFF10848420FFFF10848420 212021 424142 424121 212021 424142 424121 212021 424142

// ==== verif/tb_hdr_image.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hdr_image;

	localparam int N_WORDS = 12;
	localparam int REC = 12; // Values per line of the data file
	localparam int LINE_WIDTH = 16;
	localparam int TIMEOUT_CYCLES = 60 * N_WORDS + 200;

	logic clk = 1'b0;
	logic rst_n;
	logic hdr_en;
	logic [2:0] last_frame;
	logic frame_done;
	logic [127:0] camera_data;
	logic camera_wr_req;
	logic [127:0] rd_data = '0;
	logic rd_valid = 1'b0;
	logic ram_busy = 1'b0;
	logic rd_req;
	logic [24:0] rd_address;
	logic wr_req;
	logic [24:0] wr_address;
	logic [127:0] wr_data;
	logic [23:0] out_pixel;
	logic out_valid;
	logic line_end;

	logic [127:0] tdata [0:N_WORDS*REC-1];
	logic [31:0] lfsr = 32'he5e095f6;
	logic [127:0] rsp_data [$];
	int rsp_due [$];
	int errors = 0;
	int cycle_count = 0;
	int mem_cycle = 0;
	int last_due = 0;
	int cur_rec = 0;
	int cur_slot = 0;
	int cur_widx = 0;
	int wr_total = 0;
	int rd_total = 0;
	int out_total = 0;
	int run_len = 0;

	hdr_image_top #(.sat_level(8'd240), .line_width(LINE_WIDTH)) hdr_image_top_inst (
		.clk(clk), .rst_n(rst_n), .hdr_en(hdr_en), .last_frame(last_frame),
		.frame_done(frame_done), .camera_data(camera_data), .camera_wr_req(camera_wr_req),
		.rd_data(rd_data), .rd_valid(rd_valid), .ram_busy(ram_busy), .rd_req(rd_req),
		.rd_address(rd_address), .wr_req(wr_req), .wr_address(wr_address),
		.wr_data(wr_data), .out_pixel(out_pixel), .out_valid(out_valid), .line_end(line_end)
	);

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Galois LFSR stepped once for every random bit
	function automatic logic random_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	// Slot bases are 25800h apart in the frame memory
	function automatic logic [24:0] slot_addr(input int slot, input int widx);
		return 25'(slot * 32'h25800 + widx * 4);
	endfunction

	// Walks the bank in exposure order and skips the camera's own slot
	function automatic int read_slot(input int slot, input int which);
		int bank;
		int n;
		int found;
		bank = slot - slot % 3;
		n = 0;
		found = -1;
		for (int s = bank; s < bank + 3; s++) begin
			if (s != slot) begin
				if (n == which)
					found = s;
				n++;
			end
		end
		return found;
	endfunction

	initial begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
			$display("Errors: %0d", errors);
			$display("Some tests failed");
			$finish;
		end
	end

	// Memory model with in-order returns and random busy cycles
	always @(posedge clk) begin
		logic b0, b1, b2, b3;
		int ridx, due;
		mem_cycle++;
		if (rst_n && rd_req) begin
			ridx = rd_total - 2 * cur_rec;
			check_value(128'(rd_address), 128'(slot_addr(read_slot(cur_slot, ridx), cur_widx)),
					"rd_address");
			b0 = random_bit();
			b1 = random_bit();
			due = mem_cycle + 1 + int'({b1, b0});
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			rsp_data.push_back(tdata[cur_rec*REC + 2 + (ridx & 1)]);
			rsp_due.push_back(due);
			rd_total++;
		end
		if (rsp_due.size() > 0 && rsp_due[0] <= mem_cycle) begin
			rd_valid <= 1'b1;
			rd_data <= rsp_data.pop_front();
			void'(rsp_due.pop_front());
		end else begin
			rd_valid <= 1'b0;
		end
		b2 = random_bit();
		b3 = random_bit();
		ram_busy <= b2 & b3;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			check_value(128'(rd_req & ram_busy), 128'(0), "read request while memory busy");
			check_value(128'(wr_req & ram_busy), 128'(0), "write request while memory busy");
			if (!hdr_en)
				check_value(128'({rd_req, wr_req, out_valid}), 128'(0), "activity with hdr_en low");
			if (wr_req) begin
				check_value(128'(wr_address), 128'(slot_addr(cur_slot, cur_widx)), "wr_address");
				check_value(wr_data, tdata[cur_rec*REC + 1], "wr_data");
				wr_total++;
			end
			if (out_valid) begin
				check_value(128'(out_pixel),
						128'(tdata[(out_total/8)*REC + 4 + out_total%8][23:0]), "out_pixel");
				check_value(128'(line_end), 128'((out_total + 1) % LINE_WIDTH == 0), "line_end");
				out_total++;
				run_len++;
			end else begin
				check_value(128'(line_end), 128'(0), "line_end without out_valid");
				if (run_len != 0)
					check_value(128'(run_len), 128'(8), "out_valid run length");
				run_len = 0;
			end
		end
	end

	initial begin
		int prev_slot;
		$readmemh("verif/hdr_testdata.hex", tdata);
		rst_n = 1'b0;
		hdr_en = 1'b0;
		last_frame = 3'd0;
		frame_done = 1'b0;
		camera_data = '0;
		camera_wr_req = 1'b0;
		prev_slot = -1;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		hdr_en <= 1'b1;
		for (int r = 0; r < N_WORDS; r++) begin
			@(posedge clk);
			cur_rec = r;
			if (int'(tdata[r*REC]) != prev_slot) begin
				cur_slot = int'(tdata[r*REC]);
				cur_widx = 0;
				frame_done <= 1'b1;
				last_frame <= 3'(cur_slot);
				@(posedge clk);
				frame_done <= 1'b0;
			end else begin
				cur_widx++;
			end
			prev_slot = cur_slot;
			@(posedge clk);
			camera_data <= tdata[r*REC + 1];
			camera_wr_req <= 1'b1;
			@(posedge clk);
			camera_wr_req <= 1'b0;
			while (out_total < 8 * (r + 1))
				@(negedge clk);
			repeat (3) @(posedge clk);
		end
		check_value(128'(wr_total), 128'(N_WORDS), "write count");
		check_value(128'(rd_total), 128'(2 * N_WORDS), "read count");

		// With hdr_en low the design ignores the camera
		hdr_en <= 1'b0;
		@(posedge clk);
		frame_done <= 1'b1;
		@(posedge clk);
		frame_done <= 1'b0;
		camera_wr_req <= 1'b1;
		@(posedge clk);
		camera_wr_req <= 1'b0;
		repeat (20) @(posedge clk);

		$display("Closing: %0d errors, %0d pixels checked", errors, out_total);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/hdr_image_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdr_image_top #(
	parameter logic [7:0] sat_level = 8'd240,
	parameter int line_width = 640 // Multiple of eight pixels
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hdr_en,
	input  logic [2:0]             last_frame,
	input  logic                   frame_done,
	input  hdr_mem_pkg::word_t     camera_data,
	input  logic                   camera_wr_req,
	input  hdr_mem_pkg::word_t     rd_data,
	input  logic                   rd_valid,
	input  logic                   ram_busy,
	output logic                   rd_req,
	output hdr_mem_pkg::addr_t     rd_address,
	output logic                   wr_req,
	output hdr_mem_pkg::addr_t     wr_address,
	output hdr_mem_pkg::word_t     wr_data,
	output hdr_pixel_pkg::rgb888_t out_pixel,
	output logic                   out_valid,
	output logic                   line_end
);

	hdr_pixel_pkg::rgb888_t merged;
	logic                   merged_valid;

	exposure_word_if word_bus ();
	pixel_triplet_if pixel_bus ();

	exposure_fetch exposure_fetch_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.hdr_en        (hdr_en),
		.last_frame    (last_frame),
		.frame_done    (frame_done),
		.camera_data   (camera_data),
		.camera_wr_req (camera_wr_req),
		.rd_data       (rd_data),
		.rd_valid      (rd_valid),
		.ram_busy      (ram_busy),
		.rd_req        (rd_req),
		.rd_address    (rd_address),
		.wr_req        (wr_req),
		.wr_address    (wr_address),
		.wr_data       (wr_data),
		.words         (word_bus.source)
	);

	pixel_unpack pixel_unpack_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.words  (word_bus.sink),
		.pixels (pixel_bus.source)
	);

	hdr_merge #(.sat_level(sat_level)) hdr_merge_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.pixels       (pixel_bus.sink),
		.merged       (merged),
		.merged_valid (merged_valid)
	);

	hdr_result #(.line_width(line_width)) hdr_result_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.merged       (merged),
		.merged_valid (merged_valid),
		.out_pixel    (out_pixel),
		.out_valid    (out_valid),
		.line_end     (line_end)
	);

endmodule

`default_nettype wire

// ==== source/hdr_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdr_result #(
	parameter int line_width = 640
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  hdr_pixel_pkg::rgb888_t merged,
	input  logic                   merged_valid,
	output hdr_pixel_pkg::rgb888_t out_pixel,
	output logic                   out_valid,
	output logic                   line_end
);

	localparam int COL_W = $clog2(line_width);

	logic [COL_W-1:0] col;
	logic             last_col;

	assign last_col = (col == COL_W'(line_width - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col <= '0;
			out_valid <= 1'b0;
			line_end <= 1'b0;
		end else begin
			out_valid <= merged_valid;
			line_end <= merged_valid & last_col;
			if (merged_valid)
				col <= last_col ? '0 : col + 1'b1; // Wrap at the end of the line
		end
	end

	always_ff @(posedge clk) begin
		if (merged_valid)
			out_pixel <= merged;
	end

endmodule

`default_nettype wire

// ==== source/hdr_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdr_merge #(
	parameter logic [7:0] sat_level = 8'd240
) (
	input  logic                   clk,
	input  logic                   rst_n,
	pixel_triplet_if.sink          pixels,
	output hdr_pixel_pkg::rgb888_t merged,
	output logic                   merged_valid
);

	logic [7:0] red_sel;
	logic [7:0] green_sel;
	logic [7:0] blue_sel;

	// Bit replication keeps full scale at 8'hFF
	function automatic logic [7:0] widen5(input logic [4:0] v);
		return {v, v[4:2]};
	endfunction

	function automatic logic [7:0] widen6(input logic [5:0] v);
		return {v, v[5:4]};
	endfunction

	// Brightest unsaturated exposure wins, divided by its gain of 4 or 2
	function automatic logic [7:0] select_scale(input logic [7:0] lo, input logic [7:0] mid,
			input logic [7:0] hi);
		if (hi < sat_level)
			return hi >> 2;
		else if (mid < sat_level)
			return mid >> 1;
		return lo;
	endfunction

	assign red_sel = select_scale(widen5(pixels.px_low.red), widen5(pixels.px_mid.red),
			widen5(pixels.px_high.red));
	assign green_sel = select_scale(widen6(pixels.px_low.green), widen6(pixels.px_mid.green),
			widen6(pixels.px_high.green));
	assign blue_sel = select_scale(widen5(pixels.px_low.blue), widen5(pixels.px_mid.blue),
			widen5(pixels.px_high.blue));

	always_ff @(posedge clk) begin
		if (!rst_n)
			merged_valid <= 1'b0;
		else
			merged_valid <= pixels.valid;
	end

	always_ff @(posedge clk) begin
		if (pixels.valid)
			merged <= '{red: red_sel, green: green_sel, blue: blue_sel};
	end

endmodule

`default_nettype wire

// ==== source/pixel_unpack.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_unpack (
	input logic              clk,
	input logic              rst_n,
	exposure_word_if.sink    words,
	pixel_triplet_if.source  pixels
);

	localparam int IDX_W = $clog2(hdr_pixel_pkg::PIXELS_PER_WORD);
	localparam int PW = hdr_pixel_pkg::PIXEL_W;

	hdr_mem_pkg::word_t word_low;
	hdr_mem_pkg::word_t word_mid;
	hdr_mem_pkg::word_t word_high;
	logic [IDX_W-1:0]   idx;
	logic               busy;

	function automatic hdr_pixel_pkg::chan_t decode(input hdr_mem_pkg::word_t w,
			input logic [IDX_W-1:0] k);
		hdr_pixel_pkg::rgb565_t p;
		hdr_pixel_pkg::chan_t c;
		p = w[k*PW +: PW];
		c.red = p.red;
		c.green = {p.green_hi, p.green_lo};
		c.blue = p.blue;
		return c;
	endfunction

	// A load while busy restarts the walk, the source never does this
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (words.load) begin
			busy <= 1'b1;
			idx <= '0;
		end else if (busy) begin
			idx <= idx + 1'b1;
			if (idx == IDX_W'(hdr_pixel_pkg::PIXELS_PER_WORD - 1))
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (words.load) begin
			word_low <= words.word_low;
			word_mid <= words.word_mid;
			word_high <= words.word_high;
		end
	end

	assign pixels.valid = busy;
	assign pixels.px_low = decode(word_low, idx);
	assign pixels.px_mid = decode(word_mid, idx);
	assign pixels.px_high = decode(word_high, idx);

endmodule

`default_nettype wire

// ==== source/exposure_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module exposure_fetch (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               hdr_en,
	input  logic [2:0]         last_frame,
	input  logic               frame_done,
	input  hdr_mem_pkg::word_t camera_data,
	input  logic               camera_wr_req,
	input  hdr_mem_pkg::word_t rd_data,
	input  logic               rd_valid,
	input  logic               ram_busy,
	output logic               rd_req,
	output hdr_mem_pkg::addr_t rd_address,
	output logic               wr_req,
	output hdr_mem_pkg::addr_t wr_address,
	output hdr_mem_pkg::word_t wr_data,
	exposure_word_if.source    words
);

	hdr_mem_pkg::addr_t wr_ptr;
	hdr_mem_pkg::addr_t rd_ptr_first;
	hdr_mem_pkg::addr_t rd_ptr_second;
	hdr_mem_pkg::expo_e cam_expo;
	hdr_mem_pkg::expo_e rd_expo_first;
	hdr_mem_pkg::expo_e rd_expo_second;
	hdr_mem_pkg::expo_e new_expo;
	hdr_mem_pkg::word_t expo_word [3];
	logic [2:0] bank_base;
	logic [2:0] slot_first;
	logic [2:0] slot_second;
	logic       wr_pend;
	logic [1:0] rd_left;
	logic       issue_second; // Next read goes to the second slot
	logic       ret_second;
	logic       load;

	// The other two slots of the camera's bank, lower exposure first
	assign new_expo = hdr_mem_pkg::slot_expo(last_frame);
	assign bank_base = (last_frame >= 3'd3) ? 3'd3 : 3'd0;
	assign slot_first = bank_base + ((new_expo == hdr_mem_pkg::EXPO_LOW) ? 3'd1 : 3'd0);
	assign slot_second = bank_base + ((new_expo == hdr_mem_pkg::EXPO_HIGH) ? 3'd1 : 3'd2);

	// Write goes out before the reads, nothing leaves while the memory is busy
	assign wr_req = hdr_en & wr_pend & ~ram_busy;
	assign rd_req = hdr_en & ~wr_pend & (rd_left != 2'd0) & ~ram_busy;
	assign wr_address = wr_ptr;
	assign rd_address = issue_second ? rd_ptr_second : rd_ptr_first;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr_first <= '0;
			rd_ptr_second <= '0;
			cam_expo <= hdr_mem_pkg::EXPO_LOW;
			rd_expo_first <= hdr_mem_pkg::EXPO_MID;
			rd_expo_second <= hdr_mem_pkg::EXPO_HIGH;
			wr_pend <= 1'b0;
			rd_left <= 2'd0;
			issue_second <= 1'b0;
			ret_second <= 1'b0;
			load <= 1'b0;
		end else begin
			load <= 1'b0;
			if (hdr_en) begin
				if (frame_done) begin
					wr_ptr <= hdr_mem_pkg::slot_base(last_frame);
					rd_ptr_first <= hdr_mem_pkg::slot_base(slot_first);
					rd_ptr_second <= hdr_mem_pkg::slot_base(slot_second);
					cam_expo <= new_expo;
					rd_expo_first <= hdr_mem_pkg::slot_expo(slot_first);
					rd_expo_second <= hdr_mem_pkg::slot_expo(slot_second);
					wr_pend <= 1'b0;
					rd_left <= 2'd0;
					issue_second <= 1'b0;
					ret_second <= 1'b0;
				end else begin
					if (wr_req) begin
						wr_ptr <= wr_ptr + hdr_mem_pkg::WORD_STEP;
						wr_pend <= 1'b0;
					end
					if (rd_req) begin
						if (issue_second)
							rd_ptr_second <= rd_ptr_second + hdr_mem_pkg::WORD_STEP;
						else
							rd_ptr_first <= rd_ptr_first + hdr_mem_pkg::WORD_STEP;
						issue_second <= ~issue_second;
						rd_left <= rd_left - 2'd1;
					end
					if (camera_wr_req) begin
						wr_pend <= 1'b1;
						rd_left <= 2'd2;
					end
					if (rd_valid) begin
						ret_second <= ~ret_second;
						load <= ret_second; // Second return completes the triplet
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_en && camera_wr_req) begin
			expo_word[cam_expo] <= camera_data;
			wr_data <= camera_data;
		end
		if (hdr_en && rd_valid)
			expo_word[ret_second ? rd_expo_second : rd_expo_first] <= rd_data;
	end

	assign words.word_low = expo_word[hdr_mem_pkg::EXPO_LOW];
	assign words.word_mid = expo_word[hdr_mem_pkg::EXPO_MID];
	assign words.word_high = expo_word[hdr_mem_pkg::EXPO_HIGH];
	assign words.load = load;

endmodule

`default_nettype wire

// ==== source/hdr_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// One word of each exposure at the same position
interface exposure_word_if;
	hdr_mem_pkg::word_t word_low;
	hdr_mem_pkg::word_t word_mid;
	hdr_mem_pkg::word_t word_high;
	logic load; // Words are complete and stay stable until the next load

	modport source (output word_low, output word_mid, output word_high, output load);
	modport sink (input word_low, input word_mid, input word_high, input load);
endinterface

interface pixel_triplet_if;
	hdr_pixel_pkg::chan_t px_low;
	hdr_pixel_pkg::chan_t px_mid;
	hdr_pixel_pkg::chan_t px_high;
	logic valid;

	modport source (output px_low, output px_mid, output px_high, output valid);
	modport sink (input px_low, input px_mid, input px_high, input valid);
endinterface

`default_nettype wire

// ==== source/hdr_pixel_pkg.sv ====
`default_nettype none

package hdr_pixel_pkg;

	localparam int PIXEL_W = 16;
	localparam int PIXELS_PER_WORD = 8;

	localparam int RED_W   = 5;
	localparam int GREEN_W = 6;
	localparam int BLUE_W  = 5;

	// Byte-swapped RGB565 as the camera delivers it, green split across both bytes
	typedef struct packed {
		logic [2:0]        green_lo; // Bits 15:13
		logic [BLUE_W-1:0] blue;     // Bits 12:8
		logic [RED_W-1:0]  red;      // Bits 7:3
		logic [2:0]        green_hi; // Bits 2:0
	} rgb565_t;

	typedef struct packed {
		logic [RED_W-1:0]   red;
		logic [GREEN_W-1:0] green;
		logic [BLUE_W-1:0]  blue;
	} chan_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

endpackage

`default_nettype wire

// ==== source/hdr_mem_pkg.sv ====
`default_nettype none

package hdr_mem_pkg;

	localparam int WORD_W = 128;
	localparam int ADDR_W = 25;

	typedef logic [WORD_W-1:0] word_t; // Eight RGB565 pixels
	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic [1:0] {
		EXPO_LOW  = 2'd0,
		EXPO_MID  = 2'd1,
		EXPO_HIGH = 2'd2
	} expo_e;

	localparam addr_t WORD_STEP = addr_t'(4);

	// Two banks of three slots, low/mid/high in each bank
	function automatic addr_t slot_base(input logic [2:0] slot);
		case (slot)
			3'd0: return addr_t'(25'h00000);
			3'd1: return addr_t'(25'h25800);
			3'd2: return addr_t'(25'h4B000);
			3'd3: return addr_t'(25'h70800);
			3'd4: return addr_t'(25'h96000);
			3'd5: return addr_t'(25'hBB800);
			default: return '0;
		endcase
	endfunction

	function automatic expo_e slot_expo(input logic [2:0] slot);
		logic [2:0] r;
		r = slot % 3'd3;
		return expo_e'(r[1:0]);
	endfunction

endpackage

`default_nettype wire
